/* src/mini16_pkg.sv */
package mini16_pkg;

  // Word widths
  localparam int width_m_d = 32;
  localparam int width_p_d = 32;
  localparam int width_i = 16;

  typedef logic [width_m_d-1:0] m_word_t;
  typedef logic [width_p_d-1:0] p_word_t;
  typedef logic [width_i-1:0] instr_t;

  // I/O register index width
  localparam int io_depth = 5;

  // Master write banks
  localparam int w_bank_mem_d = 0;
  localparam int w_bank_io_reg = 1;

  // Master read banks
  localparam int r_bank_mem_d = 0;
  localparam int r_bank_io_reg = 1;
  localparam int r_bank_u2m = 2;
  localparam int r_bank_s2m = 3;

  // Loader banks, bank 1 carries the master reset word
  localparam int loader_bank_mem_i = 0;
  localparam int loader_bank_u2m = 2;

  // Harvester banks
  localparam int harvest_bank_s2m = 0;
  localparam int harvest_bank_vram = 1;

  // I/O write registers
  localparam int io_w_reset_pe = 0;
  localparam int io_w_led = 1;
  localparam int io_w_uart = 2;

  // I/O read registers
  localparam int io_r_uart_busy = 0;

  // Larger of two depths, for bank bit positions
  function automatic int depth_max(input int a, input int b);
    if (a > b)
    begin
      return a;
    end
    return b;
  endfunction

endpackage

/* src/ram_port_if.sv */
`timescale 1ns/1ps

interface ram_port_if
#(
  parameter type word_t = logic [31:0],
  parameter int addr_bits = 8
);

  // Write side
  logic [addr_bits-1:0] w_addr;
  word_t w_data;
  logic we;

  // Read side, data comes back one cycle after the address
  logic [addr_bits-1:0] r_addr;
  word_t r_data;

  modport writer (
    output w_addr,
    output w_data,
    output we
  );

  modport reader (
    output r_addr,
    input r_data
  );

  modport mem (
    input w_addr,
    input w_data,
    input we,
    input r_addr,
    output r_data
  );

endinterface

/* src/simple_dual_ram.sv */
`timescale 1ns/1ps

module simple_dual_ram
#(
  parameter type word_t = logic [31:0],
  parameter int addr_bits = 8
)
(
  input logic clk,
  ram_port_if.mem port
);

  localparam int words = 1 << addr_bits;

  word_t mem [0:words-1];

  // Write port
  always_ff @(posedge clk)
  begin
    if (port.we)
    begin
      mem[port.w_addr] <= port.w_data;
    end
  end

  // Registered read, old data on a same-address write
  always_ff @(posedge clk)
  begin
    port.r_data <= mem[port.r_addr];
  end

endmodule

/* src/master_bus_decoder.sv */
`timescale 1ns/1ps

module master_bus_decoder
  import mini16_pkg::*;
#(
  parameter int cores = 32,
  parameter int depth_m_d = 11,
  parameter int depth_u2m = 11,
  parameter int depth_s2m = 9,
  parameter int depth_p_i = 10,
  parameter int depth_m2s = 8,
  // PE ids start at 4, the top code of the bank field is the broadcast
  localparam int core_bits = $clog2(cores + 6),
  localparam int depth_v_m2s = depth_max(depth_p_i, depth_m2s) + 1,
  localparam int depth_b_m_w = depth_max(depth_v_m2s, depth_max(depth_m_d, io_depth)),
  localparam int depth_v_m_w = depth_b_m_w + core_bits,
  localparam int depth_b_m_r = depth_max(depth_max(depth_m_d, io_depth),
                                         depth_max(depth_u2m, depth_s2m)),
  localparam int depth_v_m_r = depth_b_m_r + 2
)
(
  input logic clk,
  input logic rst,
  input logic [depth_v_m_w-1:0] master_w_addr,
  input m_word_t master_w_data,
  input logic master_we,
  input logic [depth_v_m_r-1:0] master_r_addr,
  input m_word_t io_r_data,
  output logic [depth_v_m_w-1:0] pe_w_addr,
  output m_word_t pe_w_data,
  output logic pe_we,
  output logic [io_depth-1:0] io_w_index,
  output m_word_t io_w_data,
  output logic io_we,
  output logic [io_depth-1:0] io_r_index,
  output m_word_t master_r_data,
  ram_port_if.writer mem_d_w,
  ram_port_if.reader mem_d_r,
  ram_port_if.reader u2m_r,
  ram_port_if.reader s2m_r
);

  logic [core_bits-1:0] w_bank;
  logic [1:0] r_bank;
  logic [1:0] r_bank_d1;
  logic [depth_v_m_w-1:0] w_addr_d1;
  m_word_t w_data_d1;

  assign w_bank = master_w_addr[depth_v_m_w-1:depth_b_m_w];
  assign r_bank = master_r_addr[depth_v_m_r-1:depth_b_m_r];

  // Write address and data, one stage
  always_ff @(posedge clk)
  begin
    w_addr_d1 <= master_w_addr;
    w_data_d1 <= master_w_data;
  end

  // Strobes, mem_d and I/O by bank, PEs see every write
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      mem_d_w.we <= 1'b0;
      io_we <= 1'b0;
      pe_we <= 1'b0;
    end
    else
    begin
      mem_d_w.we <= master_we && (w_bank == w_bank_mem_d);
      io_we <= master_we && (w_bank == w_bank_io_reg);
      pe_we <= master_we;
    end
  end

  assign mem_d_w.w_addr = w_addr_d1[depth_m_d-1:0];
  assign mem_d_w.w_data = w_data_d1;

  assign io_w_index = w_addr_d1[io_depth-1:0];
  assign io_w_data = w_data_d1;

  assign pe_w_addr = w_addr_d1;
  assign pe_w_data = w_data_d1;

  // Read address goes to all sources at once
  assign mem_d_r.r_addr = master_r_addr[depth_m_d-1:0];
  assign u2m_r.r_addr = master_r_addr[depth_u2m-1:0];
  assign s2m_r.r_addr = master_r_addr[depth_s2m-1:0];
  assign io_r_index = master_r_addr[io_depth-1:0];

  // Bank follows the source latency
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      r_bank_d1 <= '0;
    end
    else
    begin
      r_bank_d1 <= r_bank;
    end
  end

  always_ff @(posedge clk)
  begin
    case (r_bank_d1)
      2'(r_bank_mem_d): master_r_data <= mem_d_r.r_data;
      2'(r_bank_io_reg): master_r_data <= io_r_data;
      2'(r_bank_u2m): master_r_data <= u2m_r.r_data;
      default: master_r_data <= m_word_t'(s2m_r.r_data);
    endcase
  end

endmodule

/* src/io_reg_file.sv */
`timescale 1ns/1ps

module io_reg_file
  import mini16_pkg::*;
(
  input logic clk,
  input logic rst,
  input logic [io_depth-1:0] io_w_index,
  input m_word_t io_w_data,
  input logic io_we,
  input logic [io_depth-1:0] io_r_index,
  input logic uart_busy,
  output m_word_t io_r_data,
  output logic [15:0] led,
  output logic pe_soft_reset,
  output logic [7:0] uart_tx_data,
  output logic uart_tx_we
);

  logic uart_sel;

  assign uart_sel = io_we && (io_w_index == io_w_uart);

  // LED word and PE soft reset
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      led <= '0;
      pe_soft_reset <= 1'b0;
    end
    else if (io_we)
    begin
      if (io_w_index == io_w_led)
      begin
        led <= io_w_data[15:0];
      end
      if (io_w_index == io_w_reset_pe)
      begin
        pe_soft_reset <= io_w_data[0];
      end
    end
  end

  // UART byte, the strobe lags one cycle so the byte is already in place
  always_ff @(posedge clk)
  begin
    if (uart_sel)
    begin
      uart_tx_data <= io_w_data[7:0];
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      uart_tx_we <= 1'b0;
    end
    else
    begin
      uart_tx_we <= uart_sel;
    end
  end

  // Read side, aligned with the RAM latency
  always_ff @(posedge clk)
  begin
    if (io_r_index == io_r_uart_busy)
    begin
      io_r_data <= m_word_t'(uart_busy);
    end
    else
    begin
      io_r_data <= '0;
    end
  end

endmodule

/* src/loader_router.sv */
`timescale 1ns/1ps

module loader_router
  import mini16_pkg::*;
#(
  parameter int depth_m_i = 11,
  parameter int depth_u2m = 11,
  localparam int depth_b_u = depth_max(depth_m_i, depth_u2m),
  // Bank 1, offset 0
  localparam logic [31:0] addr_reset = 32'(1 << depth_b_u)
)
(
  input logic clk,
  input logic rst,
  input logic [31:0] rx_addr,
  input logic [31:0] rx_data,
  input logic rx_we,
  output logic master_reset,
  ram_port_if.writer mem_i_w,
  ram_port_if.writer u2m_w
);

  logic [1:0] rx_bank;
  logic [31:0] rx_addr_d1;
  logic [31:0] rx_data_d1;

  assign rx_bank = rx_addr[depth_b_u+1:depth_b_u];

  always_ff @(posedge clk)
  begin
    rx_addr_d1 <= rx_addr;
    rx_data_d1 <= rx_data;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      mem_i_w.we <= 1'b0;
      u2m_w.we <= 1'b0;
      master_reset <= 1'b0;
    end
    else
    begin
      mem_i_w.we <= rx_we && (rx_bank == loader_bank_mem_i);
      u2m_w.we <= rx_we && (rx_bank == loader_bank_u2m);
      if (rx_we && (rx_addr == addr_reset))
      begin
        master_reset <= rx_data[0];
      end
    end
  end

  // Instructions take the low half of the loader word
  assign mem_i_w.w_addr = rx_addr_d1[depth_m_i-1:0];
  assign mem_i_w.w_data = rx_data_d1[width_i-1:0];
  assign u2m_w.w_addr = rx_addr_d1[depth_u2m-1:0];
  assign u2m_w.w_data = rx_data_d1[width_m_d-1:0];

endmodule

/* src/harvest_router.sv */
`timescale 1ns/1ps

module harvest_router
  import mini16_pkg::*;
#(
  parameter int depth_s2m = 9,
  parameter int depth_vram = 17,
  localparam int depth_b_f = depth_max(depth_vram, depth_s2m),
  localparam int depth_v_f = depth_b_f + 1
)
(
  input logic clk,
  input logic rst,
  input logic [depth_v_f-1:0] hv_w_addr,
  input p_word_t hv_w_data,
  input logic hv_we,
  output logic [depth_vram-1:0] vram_w_addr,
  output logic [2:0] vram_w_data,
  output logic vram_we,
  ram_port_if.writer s2m_w
);

  logic hv_bank;
  logic [depth_v_f-1:0] addr_d1;
  p_word_t data_d1;

  // Top address bit picks s2m or VRAM
  assign hv_bank = hv_w_addr[depth_v_f-1];

  always_ff @(posedge clk)
  begin
    addr_d1 <= hv_w_addr;
    data_d1 <= hv_w_data;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      s2m_w.we <= 1'b0;
      vram_we <= 1'b0;
    end
    else
    begin
      s2m_w.we <= hv_we && (hv_bank == 1'(harvest_bank_s2m));
      vram_we <= hv_we && (hv_bank == 1'(harvest_bank_vram));
    end
  end

  assign s2m_w.w_addr = addr_d1[depth_s2m-1:0];
  assign s2m_w.w_data = data_d1;

  // 3 bits per pixel
  assign vram_w_addr = addr_d1[depth_vram-1:0];
  assign vram_w_data = data_d1[2:0];

endmodule

/* src/mini16_fabric.sv */
`timescale 1ns/1ps

module mini16_fabric
  import mini16_pkg::*;
#(
  parameter int cores = 32,
  parameter int depth_m_i = 11,
  parameter int depth_m_d = 11,
  parameter int depth_u2m = 11,
  parameter int depth_s2m = 9,
  parameter int depth_p_i = 10,
  parameter int depth_m2s = 8,
  parameter int depth_vram = 17,
  // Port widths, the submodules derive the same values on their own
  localparam int core_bits = $clog2(cores + 6),
  localparam int depth_v_m2s = depth_max(depth_p_i, depth_m2s) + 1,
  localparam int depth_b_m_w = depth_max(depth_v_m2s, depth_max(depth_m_d, io_depth)),
  localparam int depth_v_m_w = depth_b_m_w + core_bits,
  localparam int depth_b_m_r = depth_max(depth_max(depth_m_d, io_depth),
                                         depth_max(depth_u2m, depth_s2m)),
  localparam int depth_v_m_r = depth_b_m_r + 2,
  localparam int depth_v_f = depth_max(depth_vram, depth_s2m) + 1
)
(
  input logic clk,
  input logic rst,
  // Master CPU data bus
  input logic [depth_v_m_w-1:0] master_w_addr,
  input m_word_t master_w_data,
  input logic master_we,
  input logic [depth_v_m_r-1:0] master_r_addr,
  output m_word_t master_r_data,
  // Master CPU fetch
  input logic [depth_m_i-1:0] imem_r_addr,
  output instr_t imem_r_data,
  // PE broadcast
  output logic [depth_v_m_w-1:0] pe_w_addr,
  output m_word_t pe_w_data,
  output logic pe_we,
  // I/O
  output logic [15:0] led,
  output logic pe_soft_reset,
  output logic [7:0] uart_tx_data,
  output logic uart_tx_we,
  input logic uart_busy,
  // Loader
  input logic [31:0] rx_addr,
  input logic [31:0] rx_data,
  input logic rx_we,
  output logic master_reset,
  // Harvester and VRAM
  input logic [depth_v_f-1:0] hv_w_addr,
  input p_word_t hv_w_data,
  input logic hv_we,
  output logic [depth_vram-1:0] vram_w_addr,
  output logic [2:0] vram_w_data,
  output logic vram_we
);

  logic [io_depth-1:0] io_w_index;
  m_word_t io_w_data;
  logic io_we;
  logic [io_depth-1:0] io_r_index;
  m_word_t io_r_data;

  ram_port_if #(.word_t(m_word_t), .addr_bits(depth_m_d)) mem_d_bus ();
  ram_port_if #(.word_t(instr_t), .addr_bits(depth_m_i)) mem_i_bus ();
  ram_port_if #(.word_t(m_word_t), .addr_bits(depth_u2m)) u2m_bus ();
  ram_port_if #(.word_t(p_word_t), .addr_bits(depth_s2m)) s2m_bus ();

  master_bus_decoder
  #(
    .cores (cores),
    .depth_m_d (depth_m_d),
    .depth_u2m (depth_u2m),
    .depth_s2m (depth_s2m),
    .depth_p_i (depth_p_i),
    .depth_m2s (depth_m2s)
  )
  master_bus_decoder_i
  (
    .clk (clk),
    .rst (rst),
    .master_w_addr (master_w_addr),
    .master_w_data (master_w_data),
    .master_we (master_we),
    .master_r_addr (master_r_addr),
    .io_r_data (io_r_data),
    .pe_w_addr (pe_w_addr),
    .pe_w_data (pe_w_data),
    .pe_we (pe_we),
    .io_w_index (io_w_index),
    .io_w_data (io_w_data),
    .io_we (io_we),
    .io_r_index (io_r_index),
    .master_r_data (master_r_data),
    .mem_d_w (mem_d_bus.writer),
    .mem_d_r (mem_d_bus.reader),
    .u2m_r (u2m_bus.reader),
    .s2m_r (s2m_bus.reader)
  );

  io_reg_file io_reg_file_i
  (
    .clk (clk),
    .rst (rst),
    .io_w_index (io_w_index),
    .io_w_data (io_w_data),
    .io_we (io_we),
    .io_r_index (io_r_index),
    .uart_busy (uart_busy),
    .io_r_data (io_r_data),
    .led (led),
    .pe_soft_reset (pe_soft_reset),
    .uart_tx_data (uart_tx_data),
    .uart_tx_we (uart_tx_we)
  );

  loader_router
  #(
    .depth_m_i (depth_m_i),
    .depth_u2m (depth_u2m)
  )
  loader_router_i
  (
    .clk (clk),
    .rst (rst),
    .rx_addr (rx_addr),
    .rx_data (rx_data),
    .rx_we (rx_we),
    .master_reset (master_reset),
    .mem_i_w (mem_i_bus.writer),
    .u2m_w (u2m_bus.writer)
  );

  harvest_router
  #(
    .depth_s2m (depth_s2m),
    .depth_vram (depth_vram)
  )
  harvest_router_i
  (
    .clk (clk),
    .rst (rst),
    .hv_w_addr (hv_w_addr),
    .hv_w_data (hv_w_data),
    .hv_we (hv_we),
    .vram_w_addr (vram_w_addr),
    .vram_w_data (vram_w_data),
    .vram_we (vram_we),
    .s2m_w (s2m_bus.writer)
  );

  // Instruction fetch reads mem_i directly
  assign mem_i_bus.r_addr = imem_r_addr;
  assign imem_r_data = mem_i_bus.r_data;

  simple_dual_ram #(.word_t(m_word_t), .addr_bits(depth_m_d)) mem_d_ram
  (
    .clk (clk),
    .port (mem_d_bus.mem)
  );

  simple_dual_ram #(.word_t(instr_t), .addr_bits(depth_m_i)) mem_i_ram
  (
    .clk (clk),
    .port (mem_i_bus.mem)
  );

  simple_dual_ram #(.word_t(m_word_t), .addr_bits(depth_u2m)) u2m_ram
  (
    .clk (clk),
    .port (u2m_bus.mem)
  );

  simple_dual_ram #(.word_t(p_word_t), .addr_bits(depth_s2m)) s2m_ram
  (
    .clk (clk),
    .port (s2m_bus.mem)
  );

endmodule

/* test/mini16_fabric_asserts.sv */
`timescale 1ns/1ps

module mini16_fabric_asserts
(
  input logic clk,
  input logic rst,
  input logic master_we,
  input logic pe_we,
  input logic uart_tx_we,
  input logic vram_we
);

  // Single-cycle pulses
  uart_pulse: assert property (@(posedge clk) disable iff (rst) uart_tx_we |=> !uart_tx_we)
    else $error("uart_tx_we stayed high for two cycles");

  vram_pulse: assert property (@(posedge clk) disable iff (rst) vram_we |=> !vram_we)
    else $error("vram_we stayed high for two cycles");

  // PE broadcast lags the master write by one cycle
  pe_follow_high: assert property (@(posedge clk) disable iff (rst) master_we |=> pe_we)
    else $error("pe_we missing one cycle after master_we");

  pe_follow_low: assert property (@(posedge clk) disable iff (rst) !master_we |=> !pe_we)
    else $error("pe_we high without a master write");

  // Strobes quiet once reset has taken effect
  reset_quiet: assert property (@(posedge clk)
    (rst && $past(rst)) |-> !(pe_we || uart_tx_we || vram_we))
    else $error("strobe high during reset");

endmodule

/* test/mini16_fabric_tb.sv */
`timescale 1ns/1ps

module mini16_fabric_tb
  import mini16_pkg::*;
();

  localparam int strobe_timeout = 20;
  localparam int sel_uart = 0;
  localparam int sel_vram = 1;
  localparam int sel_pe = 2;

  logic clk;
  logic rst;
  logic [16:0] master_w_addr;
  m_word_t master_w_data;
  logic master_we;
  logic [12:0] master_r_addr;
  m_word_t master_r_data;
  logic [10:0] imem_r_addr;
  instr_t imem_r_data;
  logic [16:0] pe_w_addr;
  m_word_t pe_w_data;
  logic pe_we;
  logic [15:0] led;
  logic pe_soft_reset;
  logic [7:0] uart_tx_data;
  logic uart_tx_we;
  logic uart_busy;
  logic [31:0] rx_addr;
  logic [31:0] rx_data;
  logic rx_we;
  logic master_reset;
  logic [17:0] hv_w_addr;
  p_word_t hv_w_data;
  logic hv_we;
  logic [16:0] vram_w_addr;
  logic [2:0] vram_w_data;
  logic vram_we;

  // Marks cycles that carry a master read to be compared
  logic read_check;
  logic [1:0] pipe_valid;
  m_word_t pipe_data [0:1];
  int errors;
  integer seed;

  // Memory map model
  m_word_t mem_d_model [int];
  instr_t mem_i_model [int];
  m_word_t u2m_model [int];
  p_word_t s2m_model [int];
  m_word_t io_r_model [int];

  mini16_fabric dut_i
  (
    .clk (clk),
    .rst (rst),
    .master_w_addr (master_w_addr),
    .master_w_data (master_w_data),
    .master_we (master_we),
    .master_r_addr (master_r_addr),
    .master_r_data (master_r_data),
    .imem_r_addr (imem_r_addr),
    .imem_r_data (imem_r_data),
    .pe_w_addr (pe_w_addr),
    .pe_w_data (pe_w_data),
    .pe_we (pe_we),
    .led (led),
    .pe_soft_reset (pe_soft_reset),
    .uart_tx_data (uart_tx_data),
    .uart_tx_we (uart_tx_we),
    .uart_busy (uart_busy),
    .rx_addr (rx_addr),
    .rx_data (rx_data),
    .rx_we (rx_we),
    .master_reset (master_reset),
    .hv_w_addr (hv_w_addr),
    .hv_w_data (hv_w_data),
    .hv_we (hv_we),
    .vram_w_addr (vram_w_addr),
    .vram_w_data (vram_w_data),
    .vram_we (vram_we)
  );

  bind mini16_fabric mini16_fabric_asserts asserts_i
  (
    .clk (clk),
    .rst (rst),
    .master_we (master_we),
    .pe_we (pe_we),
    .uart_tx_we (uart_tx_we),
    .vram_we (vram_we)
  );

  always
  begin
    #20 clk = ~clk;
  end

  // Expected master read word, bank in the top two address bits
  function automatic m_word_t ref_read(input logic [12:0] addr);
    int off;
    off = addr[10:0];
    case (addr[12:11])
      2'(r_bank_mem_d): return mem_d_model.exists(off) ? mem_d_model[off] : '0;
      2'(r_bank_io_reg):
      begin
        off = addr[4:0];
        return io_r_model.exists(off) ? io_r_model[off] : '0;
      end
      2'(r_bank_u2m): return u2m_model.exists(off) ? u2m_model[off] : '0;
      default:
      begin
        off = addr[8:0];
        return s2m_model.exists(off) ? s2m_model[off] : '0;
      end
    endcase
  endfunction

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected)
    begin
      errors++;
      $display("FAIL %0t %s: got %h, expected %h", $time, name, actual, expected);
    end
  endtask

  task automatic wait_strobe(input int sel, input string what);
    int cycles;
    bit seen;
    cycles = 0;
    seen = 1'b0;
    while (!seen && cycles < strobe_timeout)
    begin
      @(negedge clk);
      case (sel)
        sel_uart: seen = uart_tx_we;
        sel_vram: seen = vram_we;
        default: seen = pe_we;
      endcase
      cycles++;
    end
    if (!seen)
    begin
      errors++;
      $display("Timeout at %0t: %s never went high", $time, what);
    end
  endtask

  task automatic settle(input int n);
    repeat (n) @(posedge clk);
    @(negedge clk);
  endtask

  task automatic master_write(input logic [16:0] addr, input m_word_t data);
    @(posedge clk);
    master_w_addr <= addr;
    master_w_data <= data;
    master_we <= 1'b1;
    if (addr[16:11] == 6'(w_bank_mem_d))
    begin
      mem_d_model[addr[10:0]] = data;
    end
    @(posedge clk);
    master_we <= 1'b0;
  endtask

  task automatic master_read(input logic [12:0] addr);
    @(posedge clk);
    master_r_addr <= addr;
    read_check <= 1'b1;
  endtask

  task automatic end_reads();
    @(posedge clk);
    read_check <= 1'b0;
    repeat (3) @(posedge clk);
  endtask

  task automatic loader_write(input logic [31:0] addr, input logic [31:0] data);
    @(posedge clk);
    rx_addr <= addr;
    rx_data <= data;
    rx_we <= 1'b1;
    if (addr[12:11] == 2'(loader_bank_mem_i))
    begin
      mem_i_model[addr[10:0]] = data[15:0];
    end
    else if (addr[12:11] == 2'(loader_bank_u2m))
    begin
      u2m_model[addr[10:0]] = data;
    end
    @(posedge clk);
    rx_we <= 1'b0;
  endtask

  task automatic harvest_write(input logic [17:0] addr, input p_word_t data);
    @(posedge clk);
    hv_w_addr <= addr;
    hv_w_data <= data;
    hv_we <= 1'b1;
    if (addr[17] == 1'(harvest_bank_s2m))
    begin
      s2m_model[addr[8:0]] = data;
    end
    @(posedge clk);
    hv_we <= 1'b0;
  endtask

  task automatic imem_check(input logic [10:0] addr);
    @(posedge clk);
    imem_r_addr <= addr;
    @(posedge clk);
    @(negedge clk);
    check_value("imem_r_data", imem_r_data, mem_i_model[addr]);
  endtask

  // Read data lands two cycles after its address
  always @(negedge clk)
  begin
    if (rst)
    begin
      pipe_valid = '0;
    end
    else
    begin
      if (pipe_valid[1])
      begin
        check_value("master_r_data", master_r_data, pipe_data[1]);
      end
      pipe_valid[1] = pipe_valid[0];
      pipe_data[1] = pipe_data[0];
      pipe_valid[0] = read_check;
      pipe_data[0] = ref_read(master_r_addr);
    end
  end

  initial
  begin
    #200000;
    $display("Timeout: the test did not reach its end");
    $display("Errors found");
    $finish;
  end

  initial
  begin
    logic [10:0] offs [$];
    logic [16:0] addr;
    logic [17:0] hv_addr;
    m_word_t data;
    clk = 1'b0;
    errors = 0;
    seed = 69666;
    pipe_valid = '0;
    rst <= 1'b1;
    master_w_addr <= '0;
    master_w_data <= '0;
    master_we <= 1'b0;
    master_r_addr <= '0;
    imem_r_addr <= '0;
    uart_busy <= 1'b0;
    rx_addr <= '0;
    rx_data <= '0;
    rx_we <= 1'b0;
    hv_w_addr <= '0;
    hv_w_data <= '0;
    hv_we <= 1'b0;
    read_check <= 1'b0;
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);

    // Reset values
    check_value("led", led, 0);
    check_value("pe_soft_reset", pe_soft_reset, 0);
    check_value("pe_we", pe_we, 0);
    check_value("uart_tx_we", uart_tx_we, 0);
    check_value("vram_we", vram_we, 0);
    check_value("master_reset", master_reset, 0);

    // Data memory, random offsets, reads back to back
    for (int i = 0; i < 16; i++)
    begin
      offs.push_back(11'($random(seed)));
      data = $random(seed);
      master_write({6'(w_bank_mem_d), offs[i]}, data);
    end
    settle(2);
    foreach (offs[i])
    begin
      master_read({2'(r_bank_mem_d), offs[i]});
    end
    end_reads();

    // I/O registers
    data = $random(seed);
    master_write({6'(w_bank_io_reg), 6'd0, 5'(io_w_led)}, data);
    settle(1);
    check_value("led", led, data[15:0]);
    master_write({6'(w_bank_io_reg), 6'd0, 5'(io_w_reset_pe)}, 32'h1);
    settle(1);
    check_value("pe_soft_reset", pe_soft_reset, 1);
    data = $random(seed);
    master_write({6'(w_bank_io_reg), 6'd0, 5'(io_w_uart)}, data);
    wait_strobe(sel_uart, "uart_tx_we");
    check_value("uart_tx_data", uart_tx_data, data[7:0]);
    @(negedge clk);
    check_value("uart_tx_we", uart_tx_we, 0);

    @(posedge clk);
    uart_busy <= 1'b1;
    io_r_model[io_r_uart_busy] = 32'h1;
    master_read({2'(r_bank_io_reg), 6'd0, 5'(io_r_uart_busy)});
    master_read({2'(r_bank_io_reg), 6'd0, 5'd3});
    end_reads();
    uart_busy <= 1'b0;
    io_r_model[io_r_uart_busy] = 32'h0;
    master_read({2'(r_bank_io_reg), 6'd0, 5'(io_r_uart_busy)});
    end_reads();

    // PE broadcast for several banks, 63 is the broadcast code
    for (int i = 0; i < 4; i++)
    begin
      addr = 17'($random(seed));
      data = $random(seed);
      if (i == 0)
      begin
        addr[16:11] = 6'(w_bank_mem_d);
      end
      else if (i == 1)
      begin
        addr[16:11] = 6'(w_bank_io_reg);
        addr[4:0] = 5'd20;
      end
      else
      begin
        addr[16:11] = (i == 2) ? 6'd37 : 6'd63;
      end
      master_write(addr, data);
      wait_strobe(sel_pe, "pe_we");
      check_value("pe_w_addr", pe_w_addr, addr);
      check_value("pe_w_data", pe_w_data, data);
    end

    // Loader into instruction memory and u2m
    offs.delete();
    for (int i = 0; i < 8; i++)
    begin
      offs.push_back(11'($random(seed)));
      loader_write({19'd0, 2'(loader_bank_mem_i), offs[i]}, $random(seed));
    end
    foreach (offs[i])
    begin
      imem_check(offs[i]);
    end
    offs.delete();
    for (int i = 0; i < 8; i++)
    begin
      offs.push_back(11'($random(seed)));
      loader_write({19'd0, 2'(loader_bank_u2m), offs[i]}, $random(seed));
    end
    settle(1);
    foreach (offs[i])
    begin
      master_read({2'(r_bank_u2m), offs[i]});
    end
    end_reads();

    // Master reset word at bank 1 offset 0
    loader_write(32'h0000_0800, 32'h0000_0001);
    @(negedge clk);
    check_value("master_reset", master_reset, 1);
    loader_write(32'h0000_0800, 32'hffff_fffe);
    @(negedge clk);
    check_value("master_reset", master_reset, 0);

    // Harvester into s2m, then VRAM
    offs.delete();
    for (int i = 0; i < 8; i++)
    begin
      offs.push_back(11'(9'($random(seed))));
      hv_addr = {1'(harvest_bank_s2m), 8'd0, offs[i][8:0]};
      harvest_write(hv_addr, $random(seed));
    end
    settle(1);
    foreach (offs[i])
    begin
      master_read({2'(r_bank_s2m), offs[i]});
    end
    end_reads();
    for (int i = 0; i < 4; i++)
    begin
      hv_addr = {1'(harvest_bank_vram), 17'($random(seed))};
      data = $random(seed);
      harvest_write(hv_addr, data);
      wait_strobe(sel_vram, "vram_we");
      check_value("vram_w_addr", vram_w_addr, hv_addr[16:0]);
      check_value("vram_w_data", vram_w_data, data[2:0]);
    end

    settle(2);
    $display("Error count: %0d", errors);
    if (errors == 0)
    begin
      $display("No errors");
    end
    else
    begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

/* mini16_fabric.f */
src/mini16_pkg.sv
src/ram_port_if.sv
src/simple_dual_ram.sv
src/master_bus_decoder.sv
src/io_reg_file.sv
src/loader_router.sv
src/harvest_router.sv
src/mini16_fabric.sv
test/mini16_fabric_asserts.sv
test/mini16_fabric_tb.sv
